//--- flist.f
rtl/z80_bus_pkg.sv
rtl/xt_reg_pkg.sv
rtl/port_decoder.sv
rtl/xt_regfile.sv
rtl/sd_port.sv
rtl/port_read_mux.sv
rtl/zports.sv
testbench/zports_tb.sv

//--- rtl/port_decoder.sv
// low-byte address decode, porthit/dataout, one-cycle io strobes
`default_nettype none
`timescale 1ns/1ns

module port_decoder
(
	input  wire                    zclk,
	input  wire                    rst,
	input  z80_bus_pkg::z80_bus_t  bus,
	input  wire                    dos,
	output z80_bus_pkg::port_sel_t sel,
	output z80_bus_pkg::io_strobe_t strobe,
	output logic                   porthit,
	output logic                   dataout
);

	logic [7:0] loa;
	logic       iowr;
	logic       iord;
	logic       iowr_prev;
	logic       iord_prev;

	assign loa  = bus.addr[7:0];
	assign iowr = bus.iorq & bus.wr;
	assign iord = bus.iorq & bus.rd;

	always_comb
	begin
		sel.fe    = (loa == z80_bus_pkg::PORT_FE);
		sel.xt    = (loa == z80_bus_pkg::PORT_XT);
		sel.p7ffd = (loa == z80_bus_pkg::PORT_FD) & ~bus.addr[15]; // a15 high is AY
		sel.jstk  = (loa == z80_bus_pkg::PORT_KJOY) & ~dos;        // #1F belongs to fdc in dos
		sel.sdcfg = (loa == z80_bus_pkg::PORT_SDCFG) & ~dos;
		sel.sddat = (loa == z80_bus_pkg::PORT_SDDAT) & ~dos;
	end

	assign porthit = |sel;
	assign dataout = porthit & iord & ~sel.p7ffd; // #7FFD is write only

	// rising edge of each io level gives one strobe per z80 cycle
	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			iowr_prev  <= 1'b0;
			iord_prev  <= 1'b0;
			strobe.wr  <= 1'b0;
			strobe.rd  <= 1'b0;
		end
		else
		begin
			iowr_prev <= iowr;
			iord_prev <= iord;
			strobe.wr <= iowr & ~iowr_prev;
			strobe.rd <= iord & ~iord_prev;
		end
	end

	// rd and wr are exclusive on the z80 bus
	a_strobe_excl: assert property (@(posedge zclk) disable iff (rst)
		strobe.wr |-> !strobe.rd);

endmodule

`default_nettype wire

//--- rtl/port_read_mux.sv
// read data for keyboard, joystick, extended regs and sd ports
`default_nettype none
`timescale 1ns/1ns

module port_read_mux
(
	input  z80_bus_pkg::z80_bus_t  bus,
	input  z80_bus_pkg::port_sel_t sel,
	input  wire [4:0]              keys,
	input  wire [4:0]              kjoy,
	input  wire                    tape,
	input  wire [31:0]             xt_page,
	input  wire                    pwr_up,
	input  wire [7:0]              sd_rdata,
	output logic [7:0]             dout
);

	logic [7:0] hoa;
	logic [7:0] xt_rd;

	assign hoa = bus.addr[15:8];

	// readable part of the #nnAF space
	always_comb
	begin
		case (hoa)
			xt_reg_pkg::XSTAT:
				xt_rd = {2'b00, pwr_up, 5'b00000};
			xt_reg_pkg::RAMPAGE + 8'd2:
				xt_rd = xt_page[23:16];
			xt_reg_pkg::RAMPAGE + 8'd3:
				xt_rd = xt_page[31:24];
			default:
				xt_rd = z80_bus_pkg::PORT_IDLE;
		endcase
	end

	always_comb
	begin
		if (sel.fe)
			dout = {1'b1, tape, 1'b0, keys};
		else if (sel.jstk)
			dout = {3'b000, kjoy};
		else if (sel.xt)
			dout = xt_rd;
		else if (sel.sdcfg)
			dout = 8'h00; // card present, not write protected
		else if (sel.sddat)
			dout = sd_rdata;
		else
			dout = z80_bus_pkg::PORT_IDLE; // #7FFD and unmatched
	end

endmodule

`default_nettype wire

//--- rtl/sd_port.sv
// z-controller chip select, spi start pulse, send byte latch
`default_nettype none
`timescale 1ns/1ns

module sd_port
(
	input  wire                     zclk,
	input  wire                     rst,
	input  z80_bus_pkg::z80_bus_t   bus,
	input  z80_bus_pkg::port_sel_t  sel,
	input  z80_bus_pkg::io_strobe_t strobe,
	output logic                    sdcs_n,
	output logic                    sd_start,
	output logic [7:0]              sd_wdata
);

	logic [7:0] send_byte;
	logic [7:0] wdata_q;

	assign sd_start  = (strobe.wr | strobe.rd) & sel.sddat; // any access starts a transfer
	assign send_byte = strobe.wr ? bus.din : 8'hFF;          // reads clock out #FF

	// held until the next start
	always_ff @(posedge zclk)
	begin
		if (sd_start)
			wdata_q <= send_byte;
	end

	assign sd_wdata = sd_start ? send_byte : wdata_q;

	always_ff @(posedge zclk)
	begin
		if (rst)
			sdcs_n <= 1'b1;
		else if (strobe.wr && sel.sdcfg)
			sdcs_n <= bus.din[1];
	end

	a_start_pulse: assert property (@(posedge zclk) disable iff (rst)
		sd_start |=> !sd_start);

endmodule

`default_nettype wire

//--- rtl/xt_reg_pkg.sv
// extended register indices, video indices, reset values, config and video-write structs
`default_nettype none

package xt_reg_pkg;

	// #nnAF register indices
	localparam logic [7:0] XSTAT   = 8'h00; // status, read side
	localparam logic [7:0] RAMPAGE = 8'h10; // #10..#13
	localparam logic [7:0] FMADDR  = 8'h15;
	localparam logic [7:0] SYSCONF = 8'h20;
	localparam logic [7:0] MEMCONF = 8'h21;
	localparam logic [7:0] IM2VECT = 8'h25;
	localparam logic [7:0] FDDVIRT = 8'h29;

	// video registers, handed on as a write event only
	localparam logic [7:0] VCONF    = 8'h00;
	localparam logic [7:0] VPAGE    = 8'h01;
	localparam logic [7:0] GXOFFSL  = 8'h02;
	localparam logic [7:0] GXOFFSH  = 8'h03;
	localparam logic [7:0] GYOFFSL  = 8'h04;
	localparam logic [7:0] GYOFFSH  = 8'h05;
	localparam logic [7:0] TSCONF   = 8'h06;
	localparam logic [7:0] PALSEL   = 8'h07;
	localparam logic [7:0] TMPAGE   = 8'h08;
	localparam logic [7:0] T0GPAGE  = 8'h09;
	localparam logic [7:0] T1GPAGE  = 8'h0A;
	localparam logic [7:0] SGPAGE   = 8'h0B;
	localparam logic [7:0] XBORDER  = 8'h0F;
	localparam logic [7:0] T0XOFFSL = 8'h40;
	localparam logic [7:0] T0XOFFSH = 8'h41;
	localparam logic [7:0] T0YOFFSL = 8'h42;
	localparam logic [7:0] T0YOFFSH = 8'h43;
	localparam logic [7:0] T1XOFFSL = 8'h44;
	localparam logic [7:0] T1XOFFSH = 8'h45;
	localparam logic [7:0] T1YOFFSL = 8'h46;
	localparam logic [7:0] T1YOFFSH = 8'h47;
	localparam logic [7:0] HSINT    = 8'h22;
	localparam logic [7:0] VSINTL   = 8'h23;
	localparam logic [7:0] VSINTH   = 8'h24;

	localparam logic [7:0] SYSCONF_RST = 8'h01; // turbo 7 MHz
	localparam logic [7:0] MEMCONF_RST = 8'h04; // rom map off
	localparam logic [7:0] IM2VECT_RST = 8'hFF;
	// pages 3..0
	localparam logic [3:0][7:0] RAMPAGE_RST = {8'h00, 8'h02, 8'h05, 8'h00};

	typedef struct packed
	{
		logic [7:0] sysconf;
		logic [7:0] memconf;
		logic [7:0] im2vect;
		logic [3:0] fddvirt;
		logic       fmaddr_hi; // fm chip enable
		logic [3:0] fmaddr_lo;
		logic       lock48;
	} sys_cfg_t;

	typedef struct packed
	{
		logic       en;
		logic [7:0] idx;
		logic [7:0] data;
	} vid_wr_t;

endpackage

`default_nettype wire

//--- rtl/xt_regfile.sv
// #nnAF registers, #7FFD paging with 48k/128k locks, power-up flag
`default_nettype none
`timescale 1ns/1ns

module xt_regfile
(
	input  wire                     zclk,
	input  wire                     rst,
	input  z80_bus_pkg::z80_bus_t   bus,
	input  z80_bus_pkg::port_sel_t  sel,
	input  z80_bus_pkg::io_strobe_t strobe,
	output xt_reg_pkg::sys_cfg_t    cfg,
	output logic [31:0]             xt_page,
	output xt_reg_pkg::vid_wr_t     vid_wr,
	output logic                    pwr_up
);

	logic [7:0]      hoa;
	logic [3:0][7:0] rampage;
	logic [7:0]      sysconf;
	logic [7:0]      memconf;
	logic [7:0]      im2vect;
	logic [3:0]      fddvirt;
	logic            fmaddr_hi;
	logic [3:0]      fmaddr_lo;
	logic            lock48;
	logic            lock128;
	logic            xt_wr;
	logic            p7ffd_wr;
	logic            is_vid;

	assign hoa      = bus.addr[15:8];
	assign xt_wr    = strobe.wr & sel.xt;
	assign p7ffd_wr = strobe.wr & sel.p7ffd & ~lock48;
	assign lock128  = memconf[7] ? ~bus.addr[13] : memconf[6];

	always_comb
	begin
		case (hoa)
			xt_reg_pkg::VCONF,    xt_reg_pkg::VPAGE,
			xt_reg_pkg::GXOFFSL,  xt_reg_pkg::GXOFFSH,
			xt_reg_pkg::GYOFFSL,  xt_reg_pkg::GYOFFSH,
			xt_reg_pkg::TSCONF,   xt_reg_pkg::PALSEL,
			xt_reg_pkg::TMPAGE,   xt_reg_pkg::T0GPAGE,
			xt_reg_pkg::T1GPAGE,  xt_reg_pkg::SGPAGE,
			xt_reg_pkg::XBORDER,
			xt_reg_pkg::T0XOFFSL, xt_reg_pkg::T0XOFFSH,
			xt_reg_pkg::T0YOFFSL, xt_reg_pkg::T0YOFFSH,
			xt_reg_pkg::T1XOFFSL, xt_reg_pkg::T1XOFFSH,
			xt_reg_pkg::T1YOFFSL, xt_reg_pkg::T1YOFFSH,
			xt_reg_pkg::HSINT,    xt_reg_pkg::VSINTL,
			xt_reg_pkg::VSINTH:
				is_vid = 1'b1;
			default:
				is_vid = 1'b0;
		endcase
	end

	// video block takes the write in the strobe cycle
	assign vid_wr.en   = xt_wr & is_vid;
	assign vid_wr.idx  = hoa;
	assign vid_wr.data = bus.din;

	always_ff @(posedge zclk)
	begin
		if (rst)
		begin
			rampage   <= xt_reg_pkg::RAMPAGE_RST;
			sysconf   <= xt_reg_pkg::SYSCONF_RST;
			memconf   <= xt_reg_pkg::MEMCONF_RST;
			im2vect   <= xt_reg_pkg::IM2VECT_RST;
			fddvirt   <= 4'h0;
			fmaddr_hi <= 1'b0; // fm off
			lock48    <= 1'b0;
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= bus.din[4]; // rom select
			rampage[3] <= {3'b000, lock128 ? 2'b00 : bus.din[7:6], bus.din[2:0]};
			lock48     <= bus.din[5];
		end
		else if (xt_wr)
		begin
			if (hoa[7:2] == xt_reg_pkg::RAMPAGE[7:2])
				rampage[hoa[1:0]] <= bus.din;
			if (hoa == xt_reg_pkg::FMADDR)
				fmaddr_hi <= bus.din[4];
			if (hoa == xt_reg_pkg::SYSCONF)
				sysconf <= bus.din;
			if (hoa == xt_reg_pkg::MEMCONF)
				memconf <= bus.din;
			if (hoa == xt_reg_pkg::IM2VECT)
				im2vect <= bus.din;
			if (hoa == xt_reg_pkg::FDDVIRT)
				fddvirt <= bus.din[3:0];
		end
	end

	always_ff @(posedge zclk)
	begin
		if (xt_wr && hoa == xt_reg_pkg::FMADDR)
			fmaddr_lo <= bus.din[3:0];
	end

	// set at reset, gone after the first status read
	always_ff @(posedge zclk)
	begin
		if (rst)
			pwr_up <= 1'b1;
		else if (strobe.rd && sel.xt && hoa == xt_reg_pkg::XSTAT)
			pwr_up <= 1'b0;
	end

	assign xt_page       = rampage;
	assign cfg.sysconf   = sysconf;
	assign cfg.memconf   = memconf;
	assign cfg.im2vect   = im2vect;
	assign cfg.fddvirt   = fddvirt;
	assign cfg.fmaddr_hi = fmaddr_hi;
	assign cfg.fmaddr_lo = fmaddr_lo;
	assign cfg.lock48    = lock48;

	// locked #7FFD writes leave paging alone
	a_lock48_hold: assert property (@(posedge zclk) disable iff (rst)
		(strobe.wr && sel.p7ffd && lock48) |=> ($stable(rampage[3]) && $stable(memconf[0])));

endmodule

`default_nettype wire

//--- rtl/z80_bus_pkg.sv
// z80 bus struct, port select flags, strobe pair, low-byte port addresses
`default_nettype none

package z80_bus_pkg;

	// low address byte of each decoded port
	localparam logic [7:0] PORT_FE    = 8'hFE; // keyboard and tape
	localparam logic [7:0] PORT_XT    = 8'hAF; // extended regs, index in high byte
	localparam logic [7:0] PORT_FD    = 8'hFD; // #7FFD when a15 is low
	localparam logic [7:0] PORT_KJOY  = 8'h1F; // kempston joystick
	localparam logic [7:0] PORT_SDCFG = 8'h77; // sd chip select
	localparam logic [7:0] PORT_SDDAT = 8'h57; // sd data

	localparam logic [7:0] PORT_IDLE  = 8'hFF; // floating bus on unmatched reads

	// z80 bus as seen by the port block
	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  din;
		logic        iorq;
		logic        rd;
		logic        wr;
	} z80_bus_t;

	// one flag per kept port
	typedef struct packed
	{
		logic fe;
		logic jstk;
		logic xt;
		logic p7ffd;
		logic sdcfg;
		logic sddat;
	} port_sel_t;

	// single-cycle strobes, one per io cycle
	typedef struct packed
	{
		logic wr;
		logic rd;
	} io_strobe_t;

endpackage

`default_nettype wire

//--- rtl/zports.sv
// top level of the io port block, instances and wiring
`default_nettype none
`timescale 1ns/1ns

module zports
(
	input  wire                    zclk,
	input  wire                    rst,
	input  z80_bus_pkg::z80_bus_t  bus,
	input  wire                    dos,
	input  wire [4:0]              keys,
	input  wire                    tape,
	input  wire [4:0]              kjoy,
	input  wire [7:0]              sd_rdata,
	output logic [7:0]             dout,
	output logic                   dataout,
	output logic                   porthit,
	output logic [31:0]            xt_page,
	output xt_reg_pkg::sys_cfg_t   cfg,
	output xt_reg_pkg::vid_wr_t    vid_wr,
	output logic                   sdcs_n,
	output logic                   sd_start,
	output logic [7:0]             sd_wdata
);

	z80_bus_pkg::port_sel_t  sel;
	z80_bus_pkg::io_strobe_t strobe;
	logic                    pwr_up;

	port_decoder u_decoder
	(
		.zclk    (zclk),
		.rst     (rst),
		.bus     (bus),
		.dos     (dos),
		.sel     (sel),
		.strobe  (strobe),
		.porthit (porthit),
		.dataout (dataout)
	);

	xt_regfile u_regfile
	(
		.zclk    (zclk),
		.rst     (rst),
		.bus     (bus),
		.sel     (sel),
		.strobe  (strobe),
		.cfg     (cfg),
		.xt_page (xt_page),
		.vid_wr  (vid_wr),
		.pwr_up  (pwr_up)
	);

	sd_port u_sd
	(
		.zclk     (zclk),
		.rst      (rst),
		.bus      (bus),
		.sel      (sel),
		.strobe   (strobe),
		.sdcs_n   (sdcs_n),
		.sd_start (sd_start),
		.sd_wdata (sd_wdata)
	);

	port_read_mux u_rdmux
	(
		.bus      (bus),
		.sel      (sel),
		.keys     (keys),
		.kjoy     (kjoy),
		.tape     (tape),
		.xt_page  (xt_page),
		.pwr_up   (pwr_up),
		.sd_rdata (sd_rdata),
		.dout     (dout)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the zports testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module zports_tb -f flist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi
out=$(./obj_dir/Vzports_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

//--- testbench/zports_tb.sv
// clock, reset, lfsr data, bus tasks, compare tasks, directed tests, watchdog
`default_nettype none
`timescale 1ns/1ns

module zports_tb;

	localparam int BUS_CYCLES = 35; // io_write and io_read calls over all tests
	localparam int TIMEOUT_NS = (BUS_CYCLES * 5 + 8) * 8 * 2;

	logic                    zclk = 1'b0;
	logic                    rst;
	z80_bus_pkg::z80_bus_t   bus;
	logic                    dos;
	logic [4:0]              keys;
	logic                    tape;
	logic [4:0]              kjoy;
	logic [7:0]              sd_rdata;
	logic [7:0]              dout;
	logic                    dataout;
	logic                    porthit;
	logic [31:0]             xt_page;
	xt_reg_pkg::sys_cfg_t    cfg;
	xt_reg_pkg::vid_wr_t     vid_wr;
	logic                    sdcs_n;
	logic                    sd_start;
	logic [7:0]              sd_wdata;

	logic [15:0]             lfsr = 16'd87;
	int                      err_byte = 0;
	int                      err_bit = 0;
	int                      err_cfg = 0;
	int                      err_vid = 0;
	logic [7:0]              vid_cnt;
	logic [7:0]              sd_cnt;
	xt_reg_pkg::vid_wr_t     vid_seen;
	logic [7:0]              sd_seen;
	xt_reg_pkg::sys_cfg_t    exp_cfg;
	logic [3:0][7:0]         exp_page;

	zports UUT
	(
		.zclk     (zclk),
		.rst      (rst),
		.bus      (bus),
		.dos      (dos),
		.keys     (keys),
		.tape     (tape),
		.kjoy     (kjoy),
		.sd_rdata (sd_rdata),
		.dout     (dout),
		.dataout  (dataout),
		.porthit  (porthit),
		.xt_page  (xt_page),
		.cfg      (cfg),
		.vid_wr   (vid_wr),
		.sdcs_n   (sdcs_n),
		.sd_start (sd_start),
		.sd_wdata (sd_wdata)
	);

	always #4 zclk = ~zclk;

	// pulse counters, sampled away from the driving edge
	always @(negedge zclk)
	begin
		if (rst)
		begin
			vid_cnt <= 8'd0;
			sd_cnt  <= 8'd0;
		end
		else
		begin
			if (vid_wr.en)
			begin
				vid_cnt  <= vid_cnt + 8'd1;
				vid_seen <= vid_wr;
			end
			if (sd_start)
			begin
				sd_cnt  <= sd_cnt + 8'd1;
				sd_seen <= sd_wdata;
			end
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // galois, taps 16,14,13,11
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			b[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		z80_bus_pkg::z80_bus_t b;
		b = '0;
		b.addr = addr;
		b.din  = data;
		b.iorq = 1'b1;
		b.wr   = 1'b1;
		@(posedge zclk);
		bus <= b;
		repeat (3) @(posedge zclk); // iorq held 3 cycles
		bus <= '0;
		repeat (2) @(posedge zclk);
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] data,
		output logic hit, output logic den);
		z80_bus_pkg::z80_bus_t b;
		b = '0;
		b.addr = addr;
		b.iorq = 1'b1;
		b.rd   = 1'b1;
		@(posedge zclk);
		bus <= b;
		@(posedge zclk);
		@(negedge zclk); // cycle after the strobe edge
		data = dout;
		hit  = porthit;
		den  = dataout;
		repeat (2) @(posedge zclk);
		bus <= '0;
		repeat (2) @(posedge zclk);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
			err_byte++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
			err_bit++;
		end
	endtask

	task automatic check_cfg(input xt_reg_pkg::sys_cfg_t exp, input xt_reg_pkg::sys_cfg_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t ns cfg expected %h actual %h", $time, exp, act);
			err_cfg++;
		end
	endtask

	task automatic check_vid(input xt_reg_pkg::vid_wr_t exp, input xt_reg_pkg::vid_wr_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t ns vid_wr expected %h actual %h", $time, exp, act);
			err_vid++;
		end
	endtask

	task automatic check_pages();
		for (int i = 0; i < 4; i++)
			check_byte($sformatf("xt_page[%0d]", i), exp_page[i], xt_page[i*8 +: 8]);
	endtask

	task automatic reset_values();
		logic [7:0] d;
		logic       hit;
		logic       den;
		exp_page = xt_reg_pkg::RAMPAGE_RST;
		check_pages();
		check_byte("cfg.sysconf", xt_reg_pkg::SYSCONF_RST, cfg.sysconf);
		check_byte("cfg.memconf", xt_reg_pkg::MEMCONF_RST, cfg.memconf);
		check_byte("cfg.im2vect", xt_reg_pkg::IM2VECT_RST, cfg.im2vect);
		check_byte("cfg.fddvirt", 8'h00, {4'h0, cfg.fddvirt});
		check_bit("cfg.fmaddr_hi", 1'b0, cfg.fmaddr_hi);
		check_bit("cfg.lock48", 1'b0, cfg.lock48);
		check_bit("sdcs_n", 1'b1, sdcs_n);
		check_bit("sd_start", 1'b0, sd_start);
		check_bit("vid_wr.en", 1'b0, vid_wr.en);
		io_read(16'h00AF, d, hit, den);
		check_byte("dout xstat first", 8'h20, d); // power-up flag in bit 5
		io_read(16'h00AF, d, hit, den);
		check_byte("dout xstat second", 8'h00, d);
	endtask

	task automatic regfile_writes();
		logic [7:0]          b;
		logic [7:0]          d;
		logic                hit;
		logic                den;
		logic [7:0]          base;
		xt_reg_pkg::vid_wr_t exp_vid;
		exp_cfg = '0; // lock48 stays clear, every other field is written below
		base = vid_cnt;
		for (int i = 0; i < 4; i++)
		begin
			rand_byte(b);
			io_write({xt_reg_pkg::RAMPAGE + 8'(i), 8'hAF}, b);
			exp_page[i] = b;
		end
		rand_byte(b);
		io_write({xt_reg_pkg::FMADDR, 8'hAF}, b);
		exp_cfg.fmaddr_hi = b[4];
		exp_cfg.fmaddr_lo = b[3:0];
		rand_byte(b);
		io_write({xt_reg_pkg::SYSCONF, 8'hAF}, b);
		exp_cfg.sysconf = b;
		rand_byte(b);
		io_write({xt_reg_pkg::MEMCONF, 8'hAF}, b);
		exp_cfg.memconf = b;
		rand_byte(b);
		io_write({xt_reg_pkg::IM2VECT, 8'hAF}, b);
		exp_cfg.im2vect = b;
		rand_byte(b);
		io_write({xt_reg_pkg::FDDVIRT, 8'hAF}, b);
		exp_cfg.fddvirt = b[3:0];
		check_cfg(exp_cfg, cfg);
		check_pages();
		check_byte("vid_wr.en pulses, plain regs", 8'd0, vid_cnt - base);
		io_read({xt_reg_pkg::RAMPAGE + 8'd2, 8'hAF}, d, hit, den);
		check_byte("dout page 2", exp_page[2], d);
		io_read({xt_reg_pkg::RAMPAGE + 8'd3, 8'hAF}, d, hit, den);
		check_byte("dout page 3", exp_page[3], d);
		// two video indices, one from each block
		for (int i = 0; i < 2; i++)
		begin
			rand_byte(b);
			exp_vid.en   = 1'b1;
			exp_vid.idx  = (i == 0) ? xt_reg_pkg::VPAGE : xt_reg_pkg::T1YOFFSH;
			exp_vid.data = b;
			base = vid_cnt;
			io_write({exp_vid.idx, 8'hAF}, b);
			check_byte("vid_wr.en pulses", 8'd1, vid_cnt - base);
			check_vid(exp_vid, vid_seen);
		end
	endtask

	task automatic paging_7ffd();
		logic [7:0] b;
		io_write({xt_reg_pkg::MEMCONF, 8'hAF}, 8'h00);
		rand_byte(b);
		b = b & 8'hDF; // keep unlocked
		io_write(16'h7FFD, b);
		exp_cfg.memconf = {7'h00, b[4]};
		exp_page[3] = {3'b000, b[7:6], b[2:0]};
		check_cfg(exp_cfg, cfg);
		check_pages();
		io_write({xt_reg_pkg::MEMCONF, 8'hAF}, 8'h40); // 128k lock on
		rand_byte(b);
		b = (b | 8'hC0) & 8'hDF;
		io_write(16'h7FFD, b);
		exp_cfg.memconf = {7'h20, b[4]};
		exp_page[3] = {5'b00000, b[2:0]}; // bits 4..3 held at zero
		check_cfg(exp_cfg, cfg);
		check_pages();
		io_write({xt_reg_pkg::MEMCONF, 8'hAF}, 8'h00);
		rand_byte(b);
		b = b | 8'h20; // 48k lock
		io_write(16'h7FFD, b);
		exp_cfg.memconf = {7'h00, b[4]};
		exp_cfg.lock48  = 1'b1;
		exp_page[3] = {3'b000, b[7:6], b[2:0]};
		check_cfg(exp_cfg, cfg);
		io_write(16'h7FFD, ~b); // locked, ignored
		check_cfg(exp_cfg, cfg);
		check_pages();
	endtask

	task automatic read_decode();
		logic [7:0] b;
		logic [7:0] d;
		logic       hit;
		logic       den;
		rand_byte(b);
		keys <= b[4:0];
		tape <= b[5];
		kjoy <= b[7:3];
		io_read(16'hFEFE, d, hit, den);
		check_byte("dout #FE", {1'b1, b[5], 1'b0, b[4:0]}, d);
		check_bit("dataout #FE", 1'b1, den);
		io_read(16'h001F, d, hit, den);
		check_byte("dout #1F", {3'b000, b[7:3]}, d);
		dos <= 1'b1;
		io_read(16'h001F, d, hit, den);
		check_byte("dout #1F dos", 8'hFF, d);
		check_bit("porthit #1F dos", 1'b0, hit);
		dos <= 1'b0;
		io_read(16'h00FB, d, hit, den);
		check_byte("dout unmatched", 8'hFF, d);
		check_bit("porthit unmatched", 1'b0, hit);
		check_bit("dataout unmatched", 1'b0, den);
		io_read(16'h7FFD, d, hit, den); // matched but write only
		check_bit("porthit #7FFD", 1'b1, hit);
		check_bit("dataout #7FFD", 1'b0, den);
	endtask

	task automatic sd_transfers();
		logic [7:0] b;
		logic [7:0] d;
		logic       hit;
		logic       den;
		logic [7:0] base;
		rand_byte(b);
		io_write(16'h0077, b & 8'hFD);
		check_bit("sdcs_n", 1'b0, sdcs_n);
		io_write(16'h0077, b | 8'h02);
		check_bit("sdcs_n", 1'b1, sdcs_n);
		base = sd_cnt;
		io_write(16'h0057, b);
		check_byte("sd_start pulses, write", 8'd1, sd_cnt - base);
		check_byte("sd_wdata at start", b, sd_seen);
		check_byte("sd_wdata held", b, sd_wdata);
		rand_byte(b);
		sd_rdata <= b;
		base = sd_cnt;
		io_read(16'h0057, d, hit, den);
		check_byte("dout #57", b, d);
		check_byte("sd_start pulses, read", 8'd1, sd_cnt - base);
		check_byte("sd_wdata at start", 8'hFF, sd_seen);
		io_read(16'h0077, d, hit, den);
		check_byte("dout #77", 8'h00, d);
		dos <= 1'b1;
		base = sd_cnt;
		io_write(16'h0057, b);
		io_read(16'h0057, d, hit, den);
		io_write(16'h0077, 8'h00);
		check_byte("sd_start pulses, dos", 8'd0, sd_cnt - base);
		check_bit("sdcs_n dos", 1'b1, sdcs_n);
		dos <= 1'b0;
	endtask

	initial
	begin
		rst      <= 1'b1;
		bus      <= '0;
		dos      <= 1'b0;
		keys     <= 5'h00;
		tape     <= 1'b0;
		kjoy     <= 5'h00;
		sd_rdata <= 8'h00;
		repeat (8) @(posedge zclk);
		rst <= 1'b0;
		@(posedge zclk);
		reset_values();
		regfile_writes();
		paging_7ffd();
		read_decode();
		sd_transfers();
		$display("errors: byte %0d bit %0d cfg %0d vid %0d", err_byte, err_bit, err_cfg, err_vid);
		if (err_byte + err_bit + err_cfg + err_vid == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, a bus task never returned", TIMEOUT_NS);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
